/* Bender.yml */
package:
  name: core_retire

sources:
  - files:
      - source/core_cfg_pkg.sv
      - source/csr_pkg.sv
      - source/load_align.sv
      - source/wb_sequencer.sv
      - source/reg_file.sv
      - source/csr_file.sv
      - source/core_retire.sv
  - target: test
    files:
      - test/retire_chk.sv
      - test/core_retire_tb.sv

/* core_retire.f */
source/core_cfg_pkg.sv
source/csr_pkg.sv
source/load_align.sv
source/wb_sequencer.sv
source/reg_file.sv
source/csr_file.sv
source/core_retire.sv
test/retire_chk.sv
test/core_retire_tb.sv

/* source/core_cfg_pkg.sv */
package core_cfg_pkg;

    // Datapath and register file geometry.
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // Load types, matching the RV32 funct3 field of the load opcode.
    localparam logic [2:0] LD_B  = 3'b000;
    localparam logic [2:0] LD_H  = 3'b001;
    localparam logic [2:0] LD_W  = 3'b010;
    localparam logic [2:0] LD_BU = 3'b100;
    localparam logic [2:0] LD_HU = 3'b101;

    // Write-back sequencer states.
    localparam logic [1:0] WB_WAIT_IFU  = 2'b00; // Idle until a fetch strobe.
    localparam logic [1:0] WB_WAIT_CTRL = 2'b01; // Classify the instruction.
    localparam logic [1:0] WB_WAIT_MEM  = 2'b10; // Load in flight.
    localparam logic [1:0] WB_COMMIT    = 2'b11; // Finish cycle.

endpackage

/* source/core_retire.sv */
`timescale 1ns/100ps

module core_retire (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            ifu_valid_i,
    input  logic                            lsu_valid_i,
    input  logic                            memory_inst_i,
    input  logic                            wd_i,
    input  logic [core_cfg_pkg::REG_AW-1:0] wreg_i,
    input  logic [core_cfg_pkg::XLEN-1:0]   reg_wdata_i,
    input  logic [2:0]                      csr_type_i,
    input  logic [csr_pkg::CSR_AW-1:0]      csr_addr_i,
    input  logic [core_cfg_pkg::XLEN-1:0]   csr_wdata_i,
    input  logic [core_cfg_pkg::XLEN-1:0]   mem_rdata_i,
    input  logic [1:0]                      mem_offset_i,
    input  logic [2:0]                      load_type_i,
    input  logic [core_cfg_pkg::REG_AW-1:0] rs1_addr_i,
    input  logic [core_cfg_pkg::REG_AW-1:0] rs2_addr_i,
    output logic [core_cfg_pkg::XLEN-1:0]   rs1_data_o,
    output logic [core_cfg_pkg::XLEN-1:0]   rs2_data_o,
    output logic                            finish_o
);

    logic [core_cfg_pkg::XLEN-1:0]   load_data;
    logic [core_cfg_pkg::XLEN-1:0]   csr_old;
    logic                            rf_we;
    logic [core_cfg_pkg::REG_AW-1:0] rf_waddr;
    logic [core_cfg_pkg::XLEN-1:0]   rf_wdata;
    logic [2:0]                      csr_op;

    // Raw memory word to register format.
    load_align i_load_align (
        .mem_rdata_i  (mem_rdata_i),
        .mem_offset_i (mem_offset_i),
        .load_type_i  (load_type_i),
        .load_data_o  (load_data)
    );

    wb_sequencer i_wb_sequencer (
        .clk           (clk),
        .rst           (rst),
        .ifu_valid_i   (ifu_valid_i),
        .lsu_valid_i   (lsu_valid_i),
        .memory_inst_i (memory_inst_i),
        .wd_i          (wd_i),
        .wreg_i        (wreg_i),
        .reg_wdata_i   (reg_wdata_i),
        .load_data_i   (load_data),
        .csr_type_i    (csr_type_i),
        .csr_old_i     (csr_old),
        .rf_we_o       (rf_we),
        .rf_waddr_o    (rf_waddr),
        .rf_wdata_o    (rf_wdata),
        .csr_op_o      (csr_op),
        .finish_o      (finish_o)
    );

    reg_file #(
        .NUM_REGS (32)
    ) i_reg_file (
        .clk       (clk),
        .rst       (rst),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .raddr_a_i (rs1_addr_i),
        .raddr_b_i (rs2_addr_i),
        .rdata_a_o (rs1_data_o),
        .rdata_b_o (rs2_data_o)
    );

    // The address is held, so old_o stays stable through commit.
    csr_file i_csr_file (
        .clk     (clk),
        .rst     (rst),
        .op_i    (csr_op),
        .addr_i  (csr_addr_i),
        .wdata_i (csr_wdata_i),
        .old_o   (csr_old)
    );

endmodule

/* source/csr_file.sv */
`timescale 1ns/100ps

module csr_file (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [2:0]                    op_i,
    input  logic [csr_pkg::CSR_AW-1:0]    addr_i,
    input  logic [core_cfg_pkg::XLEN-1:0] wdata_i,
    output logic [core_cfg_pkg::XLEN-1:0] old_o
);

    logic [core_cfg_pkg::XLEN-1:0] mstatus;
    logic [core_cfg_pkg::XLEN-1:0] mtvec;
    logic [core_cfg_pkg::XLEN-1:0] mepc;
    logic [core_cfg_pkg::XLEN-1:0] mcause;
    logic [core_cfg_pkg::XLEN-1:0] new_val;
    logic                          write_en;

    // Current value of the addressed CSR.
    always_comb begin
        case (addr_i)
            csr_pkg::CSR_MSTATUS: old_o = mstatus;
            csr_pkg::CSR_MTVEC:   old_o = mtvec;
            csr_pkg::CSR_MEPC:    old_o = mepc;
            csr_pkg::CSR_MCAUSE:  old_o = mcause;
            default:              old_o = '0;      // Unimplemented, reads zero.
        endcase
    end

    // Read-modify-write result.
    always_comb begin
        case (op_i)
            csr_pkg::CSR_WRITE: new_val = wdata_i;
            csr_pkg::CSR_SET:   new_val = old_o | wdata_i;
            csr_pkg::CSR_CLEAR: new_val = old_o & ~wdata_i;
            default:            new_val = old_o;
        endcase
    end

    // Reserved codes 4 to 7 do not write.
    assign write_en = (op_i inside {csr_pkg::CSR_WRITE, csr_pkg::CSR_SET,
                                    csr_pkg::CSR_CLEAR});

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (write_en) begin
            case (addr_i)
                csr_pkg::CSR_MSTATUS: mstatus <= new_val;
                csr_pkg::CSR_MTVEC:   mtvec   <= new_val;
                csr_pkg::CSR_MEPC:    mepc    <= new_val;
                csr_pkg::CSR_MCAUSE:  mcause  <= new_val;
                default: begin
                    // Writes to unknown addresses are ignored.
                end
            endcase
        end
    end

endmodule

/* source/csr_pkg.sv */
package csr_pkg;

    // Width of the CSR address field in the instruction.
    localparam int CSR_AW = 12;

    // CSR operations requested by the decoder.
    localparam logic [2:0] CSR_NONE  = 3'd0;
    localparam logic [2:0] CSR_WRITE = 3'd1; // New value is the operand.
    localparam logic [2:0] CSR_SET   = 3'd2; // Old value OR operand.
    localparam logic [2:0] CSR_CLEAR = 3'd3; // Old value AND NOT operand.

    // Codes 4 to 7 are reserved and act like CSR_NONE.

    // Implemented machine-mode CSRs.
    localparam logic [CSR_AW-1:0] CSR_MSTATUS = 12'h300;
    localparam logic [CSR_AW-1:0] CSR_MTVEC   = 12'h305;
    localparam logic [CSR_AW-1:0] CSR_MEPC    = 12'h341;
    localparam logic [CSR_AW-1:0] CSR_MCAUSE  = 12'h342;

endpackage

/* source/load_align.sv */
`timescale 1ns/100ps

module load_align (
    input  logic [core_cfg_pkg::XLEN-1:0] mem_rdata_i,
    input  logic [1:0]                    mem_offset_i,
    input  logic [2:0]                    load_type_i,
    output logic [core_cfg_pkg::XLEN-1:0] load_data_o
);

    logic [core_cfg_pkg::XLEN-1:0] byte_word;
    logic [core_cfg_pkg::XLEN-1:0] half_word;
    logic [7:0]                    byte_val;
    logic [15:0]                   half_val;

    // Bytes use the full offset, halfwords only offset bit 1.
    assign byte_word = mem_rdata_i >> {mem_offset_i, 3'b000};
    assign half_word = mem_rdata_i >> {mem_offset_i[1], 4'b0000};

    assign byte_val = byte_word[7:0];
    assign half_val = half_word[15:0];

    always_comb begin
        case (load_type_i)
            core_cfg_pkg::LD_B: begin
                load_data_o = {{(core_cfg_pkg::XLEN-8){byte_val[7]}}, byte_val};
            end
            core_cfg_pkg::LD_BU: begin
                load_data_o = {{(core_cfg_pkg::XLEN-8){1'b0}}, byte_val};
            end
            core_cfg_pkg::LD_H: begin
                load_data_o = {{(core_cfg_pkg::XLEN-16){half_val[15]}}, half_val};
            end
            core_cfg_pkg::LD_HU: begin
                load_data_o = {{(core_cfg_pkg::XLEN-16){1'b0}}, half_val};
            end
            core_cfg_pkg::LD_W: begin
                load_data_o = mem_rdata_i;             // Offset ignored.
            end
            default: begin
                load_data_o = mem_rdata_i;             // Unknown type, full word.
            end
        endcase
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/100ps

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            we_i,
    input  logic [core_cfg_pkg::REG_AW-1:0] waddr_i,
    input  logic [core_cfg_pkg::XLEN-1:0]   wdata_i,
    input  logic [core_cfg_pkg::REG_AW-1:0] raddr_a_i,
    input  logic [core_cfg_pkg::REG_AW-1:0] raddr_b_i,
    output logic [core_cfg_pkg::XLEN-1:0]   rdata_a_o,
    output logic [core_cfg_pkg::XLEN-1:0]   rdata_b_o
);

    logic [core_cfg_pkg::XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0 && waddr_i < NUM_REGS) begin
            regs[waddr_i] <= wdata_i;                  // x0 writes are dropped.
        end
    end

    // x0 and addresses beyond the file read as zero.
    always_comb begin
        if (raddr_a_i == '0 || raddr_a_i >= NUM_REGS) rdata_a_o = '0;
        else                                          rdata_a_o = regs[raddr_a_i];
    end

    always_comb begin
        if (raddr_b_i == '0 || raddr_b_i >= NUM_REGS) rdata_b_o = '0;
        else                                          rdata_b_o = regs[raddr_b_i];
    end

endmodule

/* source/wb_sequencer.sv */
`timescale 1ns/100ps

module wb_sequencer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            ifu_valid_i,
    input  logic                            lsu_valid_i,
    input  logic                            memory_inst_i,
    input  logic                            wd_i,
    input  logic [core_cfg_pkg::REG_AW-1:0] wreg_i,
    input  logic [core_cfg_pkg::XLEN-1:0]   reg_wdata_i,
    input  logic [core_cfg_pkg::XLEN-1:0]   load_data_i,
    input  logic [2:0]                      csr_type_i,
    input  logic [core_cfg_pkg::XLEN-1:0]   csr_old_i,
    output logic                            rf_we_o,
    output logic [core_cfg_pkg::REG_AW-1:0] rf_waddr_o,
    output logic [core_cfg_pkg::XLEN-1:0]   rf_wdata_o,
    output logic [2:0]                      csr_op_o,
    output logic                            finish_o
);

    logic [1:0]                    state;
    logic [1:0]                    next_state;
    logic                          commit;
    logic                          csr_real;
    logic [core_cfg_pkg::XLEN-1:0] wb_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= core_cfg_pkg::WB_WAIT_IFU;
            finish_o <= 1'b0;
        end else begin
            state    <= next_state;
            finish_o <= (next_state == core_cfg_pkg::WB_COMMIT); // One cycle after commit.
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            core_cfg_pkg::WB_WAIT_IFU: begin
                if (ifu_valid_i) next_state = core_cfg_pkg::WB_WAIT_CTRL;
            end
            core_cfg_pkg::WB_WAIT_CTRL: begin
                if (memory_inst_i) next_state = core_cfg_pkg::WB_WAIT_MEM;
                else               next_state = core_cfg_pkg::WB_COMMIT;
            end
            core_cfg_pkg::WB_WAIT_MEM: begin
                if (lsu_valid_i) next_state = core_cfg_pkg::WB_COMMIT;
            end
            core_cfg_pkg::WB_COMMIT: begin
                // The finish cycle already takes the next fetch.
                if (ifu_valid_i) next_state = core_cfg_pkg::WB_WAIT_CTRL;
                else             next_state = core_cfg_pkg::WB_WAIT_IFU;
            end
            default: next_state = core_cfg_pkg::WB_WAIT_IFU;
        endcase
    end

    // Writes land at the end of the cycle that enters WB_COMMIT.
    assign commit = (next_state == core_cfg_pkg::WB_COMMIT);

    assign csr_real = (csr_type_i inside {csr_pkg::CSR_WRITE, csr_pkg::CSR_SET,
                                          csr_pkg::CSR_CLEAR});

    always_comb begin
        if (memory_inst_i)  wb_data = load_data_i;
        else if (csr_real)  wb_data = csr_old_i;   // CSR reads return the old value.
        else                wb_data = reg_wdata_i;
    end

    assign rf_we_o    = commit & wd_i;
    assign rf_waddr_o = commit ? wreg_i : '0;
    assign rf_wdata_o = commit ? wb_data : '0;
    assign csr_op_o   = (commit && csr_real) ? csr_type_i : csr_pkg::CSR_NONE;

endmodule

/* test/core_retire_tb.sv */
`timescale 1ns/100ps

module core_retire_tb;

    localparam int NUM_INSTR  = 200;
    localparam int MAX_CYCLES = NUM_INSTR * 10 + 50;

    logic        clk;
    logic        rst;
    logic        ifu_valid_i;
    logic        lsu_valid_i;
    logic        memory_inst_i;
    logic        wd_i;
    logic [4:0]  wreg_i;
    logic [31:0] reg_wdata_i;
    logic [2:0]  csr_type_i;
    logic [11:0] csr_addr_i;
    logic [31:0] csr_wdata_i;
    logic [31:0] mem_rdata_i;
    logic [1:0]  mem_offset_i;
    logic [2:0]  load_type_i;
    logic [4:0]  rs1_addr_i;
    logic [4:0]  rs2_addr_i;
    logic [31:0] rs1_data_o;
    logic [31:0] rs2_data_o;
    logic        finish_o;

    logic [31:0] model_regs [32];
    logic [31:0] model_csr [5];            // Slot 4 stands for any unknown address.
    logic [11:0] csr_addrs [5];
    int          errors;
    int          cycle_cnt;

    core_retire i_core_retire (
        .clk           (clk),
        .rst           (rst),
        .ifu_valid_i   (ifu_valid_i),
        .lsu_valid_i   (lsu_valid_i),
        .memory_inst_i (memory_inst_i),
        .wd_i          (wd_i),
        .wreg_i        (wreg_i),
        .reg_wdata_i   (reg_wdata_i),
        .csr_type_i    (csr_type_i),
        .csr_addr_i    (csr_addr_i),
        .csr_wdata_i   (csr_wdata_i),
        .mem_rdata_i   (mem_rdata_i),
        .mem_offset_i  (mem_offset_i),
        .load_type_i   (load_type_i),
        .rs1_addr_i    (rs1_addr_i),
        .rs2_addr_i    (rs2_addr_i),
        .rs1_data_o    (rs1_data_o),
        .rs2_data_o    (rs2_data_o),
        .finish_o      (finish_o)
    );

    always #50 clk = ~clk;

    function automatic int csr_index(input logic [11:0] addr);
        case (addr)
            12'h300: return 0;
            12'h305: return 1;
            12'h341: return 2;
            12'h342: return 3;
            default: return 4;
        endcase
    endfunction

    // Expected destination value and new CSR value of one instruction.
    function automatic void ref_retire(
        input  logic        mem,
        input  logic [31:0] wdata,
        input  logic [2:0]  ctype,
        input  logic [31:0] csr_old,
        input  logic [31:0] cwdata,
        input  logic [31:0] rdata,
        input  logic [1:0]  off,
        input  logic [2:0]  ltype,
        output logic [31:0] rd_val,
        output logic [31:0] csr_new
    );
        logic [7:0]  b;
        logic [15:0] h;
        b = rdata[off*8 +: 8];
        h = off[1] ? rdata[31:16] : rdata[15:0];
        case (ctype)
            3'd1:    csr_new = cwdata;
            3'd2:    csr_new = csr_old | cwdata;
            3'd3:    csr_new = csr_old & ~cwdata;
            default: csr_new = csr_old;
        endcase
        if (mem) begin
            case (ltype)
                3'b000:  rd_val = {{24{b[7]}}, b};
                3'b100:  rd_val = {24'h0, b};
                3'b001:  rd_val = {{16{h[15]}}, h};
                3'b101:  rd_val = {16'h0, h};
                default: rd_val = rdata;       // Word and unknown types.
            endcase
        end else if (ctype >= 3'd1 && ctype <= 3'd3) begin
            rd_val = csr_old;
        end else begin
            rd_val = wdata;
        end
    endfunction

    // Register contents after each finish.
    always @(negedge clk) begin
        if (!rst && finish_o) begin
            if (rs1_data_o !== model_regs[rs1_addr_i]) begin
                $display("MISMATCH rs1_data_o (x%0d): got %h expected %h",
                         rs1_addr_i, rs1_data_o, model_regs[rs1_addr_i]);
                errors++;
            end
            if (rs2_data_o !== model_regs[rs2_addr_i]) begin
                $display("MISMATCH rs2_data_o (x%0d): got %h expected %h",
                         rs2_addr_i, rs2_data_o, model_regs[rs2_addr_i]);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // All registers read zero straight after reset.
    task automatic reset_sweep();
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            rs1_addr_i <= i;
            rs2_addr_i <= 31 - i;
            @(negedge clk);
            if (rs1_data_o !== 32'h0 || rs2_data_o !== 32'h0) begin
                $display("MISMATCH rs1_data_o/rs2_data_o after reset: got %h/%h expected 0",
                         rs1_data_o, rs2_data_o);
                errors++;
            end
            if (finish_o !== 1'b0) begin
                $display("MISMATCH finish_o after reset: got %h expected 0", finish_o);
                errors++;
            end
        end
    endtask

    task automatic issue_instr(
        input logic        mem,
        input logic        wd,
        input logic [4:0]  rd,
        input logic [31:0] wdata,
        input logic [2:0]  ctype,
        input logic [11:0] caddr,
        input logic [31:0] cwdata,
        input logic [31:0] rdata,
        input logic [1:0]  off,
        input logic [2:0]  ltype,
        input int          delay
    );
        logic [31:0] rd_val;
        logic [31:0] csr_new;
        int          slot;
        int          fin_cycle;
        slot = csr_index(caddr);
        ref_retire(mem, wdata, ctype, model_csr[slot], cwdata, rdata, off, ltype,
                   rd_val, csr_new);
        fin_cycle = mem ? 3 + delay : 2;

        @(posedge clk);
        ifu_valid_i   <= 1'b1;
        lsu_valid_i   <= $urandom % 2;       // Ignored in the idle state.
        memory_inst_i <= mem;
        wd_i          <= wd;
        wreg_i        <= rd;
        reg_wdata_i   <= wdata;
        csr_type_i    <= ctype;
        csr_addr_i    <= caddr;
        csr_wdata_i   <= cwdata;
        mem_rdata_i   <= rdata;
        mem_offset_i  <= off;
        load_type_i   <= ltype;
        rs1_addr_i    <= rd;
        rs2_addr_i    <= $urandom % 32;
        if (wd && rd != 0) model_regs[rd] = rd_val;
        if (!mem && slot < 4) model_csr[slot] = csr_new;
        @(negedge clk);
        if (finish_o) begin
            $display("MISMATCH finish_o in fetch cycle: got 1 expected 0");
            errors++;
        end

        for (int k = 1; k <= fin_cycle; k++) begin
            @(posedge clk);
            // Stray fetch strobes while busy; the finish cycle would accept one.
            ifu_valid_i <= (k < fin_cycle) ? ($urandom % 2) : 1'b0;
            if (mem) lsu_valid_i <= (k == 2 + delay);
            else     lsu_valid_i <= (k == 1) && ($urandom % 2);
            @(negedge clk);
            if (k < fin_cycle && finish_o) begin
                $display("MISMATCH finish_o at cycle %0d: got 1 expected 0", k);
                errors++;
            end
        end
        if (!finish_o) begin
            $display("finish_o did not rise %0d cycles after the fetch strobe", fin_cycle);
            errors++;
            while (!finish_o) @(negedge clk);
        end
    endtask

    initial begin
        logic [2:0] ctype;
        int         kind;
        int         chk_fails;
        clk           = 1'b0;
        rst           = 1'b1;
        ifu_valid_i   = 1'b0;
        lsu_valid_i   = 1'b0;
        memory_inst_i = 1'b0;
        wd_i          = 1'b0;
        wreg_i        = '0;
        reg_wdata_i   = '0;
        csr_type_i    = '0;
        csr_addr_i    = '0;
        csr_wdata_i   = '0;
        mem_rdata_i   = '0;
        mem_offset_i  = '0;
        load_type_i   = '0;
        rs1_addr_i    = '0;
        rs2_addr_i    = '0;
        errors        = 0;
        cycle_cnt     = 0;
        csr_addrs     = '{12'h300, 12'h305, 12'h341, 12'h342, 12'h7c0};
        foreach (model_regs[i]) model_regs[i] = '0;
        foreach (model_csr[i]) model_csr[i] = '0;
        void'($urandom(32'h2d45_87d4));

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        reset_sweep();

        // Every CSR reads zero after reset; a set with zero leaves it unchanged.
        for (int i = 0; i < 5; i++) begin
            issue_instr(1'b0, 1'b1, i + 1, 32'h0, 3'd2, csr_addrs[i], 32'h0,
                        32'h0, 2'd0, 3'd0, 0);
        end

        for (int n = 0; n < NUM_INSTR; n++) begin
            kind = $urandom % 3;
            if (kind != 2)          ctype = 3'd0;
            else if ($urandom % 8)  ctype = 1 + $urandom % 3;
            else                    ctype = 4 + $urandom % 4;   // Reserved codes.
            issue_instr(kind == 1, ($urandom % 8) != 0, $urandom % 32, $urandom, ctype,
                        csr_addrs[$urandom % 5], $urandom, $urandom, $urandom % 4,
                        $urandom % 8, $urandom % 5);
        end

        repeat (2) @(negedge clk);
        chk_fails = i_core_retire.i_wb_sequencer.i_retire_chk.assert_fails;
        $display("Run complete: %0d errors, %0d assertion failures", errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* test/retire_chk.sv */
`timescale 1ns/100ps

module retire_chk (
    input logic        clk,
    input logic        rst,
    input logic [1:0]  state,
    input logic        memory_inst_i,
    input logic        lsu_valid_i,
    input logic        rf_we_o,
    input logic [4:0]  rf_waddr_o,
    input logic [31:0] rf_wdata_o,
    input logic [2:0]  csr_op_o,
    input logic        finish_o
);

    logic commit_cycle;
    int   assert_fails = 0;

    // Register ops commit in the classify cycle and loads on the LSU strobe.
    assign commit_cycle = (state == core_cfg_pkg::WB_WAIT_CTRL && !memory_inst_i) ||
                          (state == core_cfg_pkg::WB_WAIT_MEM && lsu_valid_i);

    // Finish is a single-cycle pulse.
    finish_single: assert property (@(posedge clk) disable iff (rst)
        finish_o |=> !finish_o)
        else begin
            $error("finish_o high two cycles in a row");
            assert_fails++;
        end

    finish_after_commit: assert property (@(posedge clk) disable iff (rst)
        finish_o |-> $past(commit_cycle))
        else begin
            $error("finish_o without a commit cycle before it");
            assert_fails++;
        end

    // Write strobes only during commit.
    strobes_idle: assert property (@(posedge clk) disable iff (rst)
        !commit_cycle |-> (!rf_we_o && rf_waddr_o == '0 && rf_wdata_o == '0 &&
                           csr_op_o == csr_pkg::CSR_NONE))
        else begin
            $error("write strobes active outside a commit");
            assert_fails++;
        end

    no_commit_idle: assert property (@(posedge clk) disable iff (rst)
        (state == core_cfg_pkg::WB_WAIT_IFU) |->
            (!rf_we_o && csr_op_o == csr_pkg::CSR_NONE))
        else begin
            $error("commit while waiting for a fetch");
            assert_fails++;
        end

endmodule

bind wb_sequencer retire_chk i_retire_chk (
    .clk           (clk),
    .rst           (rst),
    .state         (state),
    .memory_inst_i (memory_inst_i),
    .lsu_valid_i   (lsu_valid_i),
    .rf_we_o       (rf_we_o),
    .rf_waddr_o    (rf_waddr_o),
    .rf_wdata_o    (rf_wdata_o),
    .csr_op_o      (csr_op_o),
    .finish_o      (finish_o)
);
